//--- verilog/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// data path width
`define EXEC_DATA_W 32

// general register file address width
`define EXEC_REG_ADDR_W 5

// shift amount taken from operand 1
`define EXEC_SHAMT_W 5

// value of HI and LO out of reset
`define EXEC_HILO_RESET 32'h0000_0000

`endif

//--- verilog/exec_pkg.sv
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

	typedef logic [`EXEC_DATA_W-1:0] word_t;
	typedef logic [`EXEC_REG_ADDR_W-1:0] reg_addr_t;

	// sub-operation codes, same 8-bit field as the decode stage
	typedef enum logic [7:0] {
		EXE_NOP_OP   = 8'b0000_0000,
		EXE_AND_OP   = 8'b0010_0100,
		EXE_OR_OP    = 8'b0010_0101,
		EXE_XOR_OP   = 8'b0010_0110,
		EXE_NOR_OP   = 8'b0010_0111,
		EXE_SLL_OP   = 8'b0111_1100,
		EXE_SRL_OP   = 8'b0000_0010,
		EXE_SRA_OP   = 8'b0000_0011,
		EXE_ADD_OP   = 8'b0010_0000,
		EXE_ADDU_OP  = 8'b0010_0001,
		EXE_SUB_OP   = 8'b0010_0010,
		EXE_SUBU_OP  = 8'b0010_0011,
		EXE_SLT_OP   = 8'b0010_1010,
		EXE_SLTU_OP  = 8'b0010_1011,
		EXE_CLZ_OP   = 8'b1011_0000,
		EXE_CLO_OP   = 8'b1011_0001,
		EXE_MUL_OP   = 8'b1010_1001,
		EXE_MULT_OP  = 8'b0001_1000,
		EXE_MULTU_OP = 8'b0001_1001,
		EXE_MFHI_OP  = 8'b0001_0000,
		EXE_MTHI_OP  = 8'b0001_0001,
		EXE_MFLO_OP  = 8'b0001_0010,
		EXE_MTLO_OP  = 8'b0001_0011
	} aluop_t;

	// which unit feeds the write-back word
	typedef enum logic [2:0] {
		EXE_RES_NONE  = 3'b000,
		EXE_RES_LOGIC = 3'b001,
		EXE_RES_SHIFT = 3'b010,
		EXE_RES_MOVE  = 3'b011,
		EXE_RES_ARITH = 3'b100,
		EXE_RES_MUL   = 3'b101
	} alusel_t;

endpackage

`default_nettype wire

//--- verilog/logic_shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module logic_shift_unit (
	input  exec_pkg::aluop_t aluop_i,
	input  exec_pkg::word_t  reg1_i,
	input  exec_pkg::word_t  reg2_i,
	output exec_pkg::word_t  logic_res_o,
	output exec_pkg::word_t  shift_res_o
);

	import exec_pkg::*;

	// shift amount sits in the low bits of operand 1
	logic [`EXEC_SHAMT_W-1:0] shamt;

	assign shamt = reg1_i[`EXEC_SHAMT_W-1:0];

	always_comb begin
		case (aluop_i)
			EXE_AND_OP: logic_res_o = reg1_i & reg2_i;
			EXE_OR_OP:  logic_res_o = reg1_i | reg2_i;
			EXE_XOR_OP: logic_res_o = reg1_i ^ reg2_i;
			EXE_NOR_OP: logic_res_o = ~(reg1_i | reg2_i);
			default:    logic_res_o = '0;
		endcase
	end

	// operand 2 is the value being shifted
	always_comb begin
		case (aluop_i)
			EXE_SLL_OP: shift_res_o = reg2_i << shamt;
			EXE_SRL_OP: shift_res_o = reg2_i >> shamt;
			EXE_SRA_OP: shift_res_o = word_t'($signed(reg2_i) >>> shamt);
			default:    shift_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/arith_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module arith_unit (
	input  exec_pkg::aluop_t aluop_i,
	input  exec_pkg::word_t  reg1_i,
	input  exec_pkg::word_t  reg2_i,
	output exec_pkg::word_t  arith_res_o,
	output logic             overflow_o
);

	import exec_pkg::*;

	localparam int MSB   = `EXEC_DATA_W - 1;
	localparam int CNT_W = $clog2(`EXEC_DATA_W + 1);

	word_t            sum;
	word_t            diff;
	logic             add_ovf;
	logic             sub_ovf;
	logic [CNT_W-1:0] clz_cnt;
	logic [CNT_W-1:0] clo_cnt;

	// priority encoder, first set bit from the top
	function automatic logic [CNT_W-1:0] lead_zero_cnt(input word_t v);
		logic [CNT_W-1:0] cnt;
		logic             found;
		cnt   = CNT_W'(`EXEC_DATA_W);
		found = 1'b0;
		for (int i = MSB; i >= 0; i--) begin
			if (!found && v[i]) begin
				cnt   = CNT_W'(MSB - i);
				found = 1'b1;
			end
		end
		return cnt;
	endfunction

	assign sum  = reg1_i + reg2_i;
	assign diff = reg1_i - reg2_i;

	// same operand signs but result sign flipped
	assign add_ovf = (reg1_i[MSB] == reg2_i[MSB]) && (sum[MSB] != reg1_i[MSB]);
	// subtract negates operand 2, so its sign counts inverted
	assign sub_ovf = (reg1_i[MSB] == ~reg2_i[MSB]) && (diff[MSB] != reg1_i[MSB]);

	// leading ones are leading zeros of the complement
	assign clz_cnt = lead_zero_cnt(reg1_i);
	assign clo_cnt = lead_zero_cnt(~reg1_i);

	always_comb begin
		case (aluop_i)
			EXE_ADD_OP:  overflow_o = add_ovf;
			EXE_SUB_OP:  overflow_o = sub_ovf;
			default:     overflow_o = 1'b0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			EXE_ADD_OP, EXE_ADDU_OP: arith_res_o = sum;
			EXE_SUB_OP, EXE_SUBU_OP: arith_res_o = diff;
			EXE_SLT_OP:  arith_res_o = word_t'($signed(reg1_i) < $signed(reg2_i));
			EXE_SLTU_OP: arith_res_o = word_t'(reg1_i < reg2_i);
			EXE_CLZ_OP:  arith_res_o = word_t'(clz_cnt);
			EXE_CLO_OP:  arith_res_o = word_t'(clo_cnt);
			default:     arith_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/mult_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module mult_unit (
	input  exec_pkg::aluop_t aluop_i,
	input  exec_pkg::word_t  reg1_i,
	input  exec_pkg::word_t  reg2_i,
	output exec_pkg::word_t  prod_hi_o,
	output exec_pkg::word_t  prod_lo_o
);

	import exec_pkg::*;

	localparam int MSB    = `EXEC_DATA_W - 1;
	localparam int PROD_W = 2 * `EXEC_DATA_W + 2;

	logic                     is_signed;
	logic signed [`EXEC_DATA_W:0] op_a;
	logic signed [`EXEC_DATA_W:0] op_b;
	logic signed [PROD_W-1:0] prod;

	// one signed multiplier with a zero extension bit for unsigned
	assign is_signed = (aluop_i != EXE_MULTU_OP);
	assign op_a      = {is_signed & reg1_i[MSB], reg1_i};
	assign op_b      = {is_signed & reg2_i[MSB], reg2_i};
	assign prod      = PROD_W'(op_a) * PROD_W'(op_b);

	assign prod_hi_o = prod[2*`EXEC_DATA_W-1:`EXEC_DATA_W];
	assign prod_lo_o = prod[MSB:0];

endmodule

`default_nettype wire

//--- verilog/hilo_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module hilo_file (
	input  logic            clk,
	input  logic            arst_n_i,
	input  logic            pend_we_i,
	input  exec_pkg::word_t pend_hi_i,
	input  exec_pkg::word_t pend_lo_i,
	output exec_pkg::word_t hi_o,
	output exec_pkg::word_t lo_o
);

	import exec_pkg::*;

	word_t hi_q;
	word_t lo_q;

	// committed values, loaded from the EX/MEM register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hi_q <= `EXEC_HILO_RESET;
			lo_q <= `EXEC_HILO_RESET;
		end else if (pend_we_i) begin
			hi_q <= pend_hi_i;
			lo_q <= pend_lo_i;
		end
	end

	// forward the write still sitting in EX/MEM
	always_comb begin
		if (pend_we_i) begin
			hi_o = pend_hi_i;
			lo_o = pend_lo_i;
		end else begin
			hi_o = hi_q;
			lo_o = lo_q;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               valid_i,
	input  exec_pkg::aluop_t   aluop_i,
	input  exec_pkg::word_t    reg1_i,
	input  exec_pkg::word_t    reg2_i,
	input  exec_pkg::reg_addr_t wd_i,
	input  logic               wreg_i,
	output logic               valid_o,
	output logic               wreg_o,
	output logic               whilo_o,
	output exec_pkg::reg_addr_t wd_o,
	output exec_pkg::word_t    wdata_o,
	output exec_pkg::word_t    hi_o,
	output exec_pkg::word_t    lo_o
);

	import exec_pkg::*;

	alusel_t alusel;
	word_t   logic_res;
	word_t   shift_res;
	word_t   arith_res;
	word_t   prod_hi;
	word_t   prod_lo;
	word_t   hi_fwd;
	word_t   lo_fwd;
	logic    overflow;
	word_t   wdata_d;
	logic    whilo_d;
	word_t   hi_d;
	word_t   lo_d;

	logic_shift_unit u_logic_shift (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res)
	);

	arith_unit u_arith (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.arith_res_o (arith_res),
		.overflow_o  (overflow)
	);

	mult_unit u_mult (
		.aluop_i   (aluop_i),
		.reg1_i    (reg1_i),
		.reg2_i    (reg2_i),
		.prod_hi_o (prod_hi),
		.prod_lo_o (prod_lo)
	);

	// pending write is whatever EX/MEM holds right now
	hilo_file u_hilo (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.pend_we_i (whilo_o),
		.pend_hi_i (hi_o),
		.pend_lo_i (lo_o),
		.hi_o      (hi_fwd),
		.lo_o      (lo_fwd)
	);

	// result group from the op code
	always_comb begin
		case (aluop_i)
			EXE_AND_OP, EXE_OR_OP, EXE_XOR_OP, EXE_NOR_OP: alusel = EXE_RES_LOGIC;
			EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP:            alusel = EXE_RES_SHIFT;
			EXE_MFHI_OP, EXE_MFLO_OP:                      alusel = EXE_RES_MOVE;
			EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP,
			EXE_SLT_OP, EXE_SLTU_OP, EXE_CLZ_OP, EXE_CLO_OP: alusel = EXE_RES_ARITH;
			EXE_MUL_OP:                                    alusel = EXE_RES_MUL;
			default:                                       alusel = EXE_RES_NONE;
		endcase
	end

	always_comb begin
		case (alusel)
			EXE_RES_LOGIC: wdata_d = logic_res;
			EXE_RES_SHIFT: wdata_d = shift_res;
			EXE_RES_MOVE:  wdata_d = (aluop_i == EXE_MFHI_OP) ? hi_fwd : lo_fwd;
			EXE_RES_ARITH: wdata_d = arith_res;
			EXE_RES_MUL:   wdata_d = prod_lo;
			default:       wdata_d = '0;
		endcase
	end

	// HI/LO write; a move keeps the other half as forwarded
	always_comb begin
		whilo_d = 1'b1;
		hi_d    = hi_fwd;
		lo_d    = lo_fwd;
		case (aluop_i)
			EXE_MULT_OP, EXE_MULTU_OP: begin
				hi_d = prod_hi;
				lo_d = prod_lo;
			end
			EXE_MTHI_OP: hi_d = reg1_i;
			EXE_MTLO_OP: lo_d = reg1_i;
			default:     whilo_d = 1'b0;
		endcase
	end

	// EX/MEM control bits
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			wreg_o  <= 1'b0;
			whilo_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			wreg_o  <= valid_i & wreg_i & ~overflow;
			whilo_o <= valid_i & whilo_d;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		wd_o    <= wd_i;
		wdata_o <= wdata_d;
		hi_o    <= hi_d;
		lo_o    <= lo_d;
	end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS  = 4.0,
	parameter int  RST_CYCLES = 4
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

	// release on a falling edge, away from the flops' sampling edge
	initial begin
		arst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module tb_ex_stage;

	import exec_pkg::*;

	localparam int RST_CYCLES  = 4;
	localparam int N_RAND      = 12;
	// random rounds of 30 ops plus directed overflow and corner cases
	localparam int N_OPS       = 1 + N_RAND * 30 + 8 + 60;
	localparam int STIM_CYCLES = RST_CYCLES + N_OPS + N_OPS / 4 + 2;
	localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

	logic      clk;
	logic      arst_n;
	logic      valid_i;
	aluop_t    aluop_i;
	word_t     reg1_i;
	word_t     reg2_i;
	reg_addr_t wd_i;
	logic      wreg_i;
	logic      valid_o;
	logic      wreg_o;
	logic      whilo_o;
	reg_addr_t wd_o;
	word_t     wdata_o;
	word_t     hi_o;
	word_t     lo_o;

	// reference HI/LO and the single result in flight
	word_t     hi_m;
	word_t     lo_m;
	logic      exp_valid;
	logic      exp_wreg;
	logic      exp_whilo;
	logic      exp_has_data;
	reg_addr_t exp_wd;
	word_t     exp_wdata;
	word_t     exp_hi;
	word_t     exp_lo;
	logic      idle_en;
	string     test_name;
	int        cycle_cnt = 0;

	aluop_t ls_ops [7] = '{EXE_AND_OP, EXE_OR_OP, EXE_XOR_OP, EXE_NOR_OP,
		EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP};
	aluop_t add_ops [4] = '{EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP};
	aluop_t cmp_ops [4] = '{EXE_SLT_OP, EXE_SLTU_OP, EXE_CLZ_OP, EXE_CLO_OP};
	word_t  corners [5] = '{32'h0000_0000, 32'hffff_ffff, 32'h7fff_ffff,
		32'h8000_0000, 32'h0000_0001};

	tb_clock_gen #(
		.PERIOD_NS  (4.0),
		.RST_CYCLES (RST_CYCLES)
	) u_clock_gen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	ex_stage UUT (
		.clk      (clk),
		.arst_n_i (arst_n),
		.valid_i  (valid_i),
		.aluop_i  (aluop_i),
		.reg1_i   (reg1_i),
		.reg2_i   (reg2_i),
		.wd_i     (wd_i),
		.wreg_i   (wreg_i),
		.valid_o  (valid_o),
		.wreg_o   (wreg_o),
		.whilo_o  (whilo_o),
		.wd_o     (wd_o),
		.wdata_o  (wdata_o),
		.hi_o     (hi_o),
		.lo_o     (lo_o)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	// number of equal bits from the top of the word
	function automatic int count_lead(input word_t v, input logic bit_val);
		int n;
		n = 0;
		while (n < `EXEC_DATA_W && v[`EXEC_DATA_W-1-n] == bit_val) begin
			n++;
		end
		return n;
	endfunction

	task automatic mismatch(input string sig, input word_t exp, input word_t act);
		$display("FAILED %s: %s expected %h actual %h", test_name, sig, exp, act);
		$display("*** FAILED ***");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_outputs();
		assert (valid_o === exp_valid)
			else mismatch("valid_o", word_t'(exp_valid), word_t'(valid_o));
		assert (wreg_o === exp_wreg)
			else mismatch("wreg_o", word_t'(exp_wreg), word_t'(wreg_o));
		assert (whilo_o === exp_whilo)
			else mismatch("whilo_o", word_t'(exp_whilo), word_t'(whilo_o));
		if (exp_valid) begin
			assert (wd_o === exp_wd) else mismatch("wd_o", word_t'(exp_wd), word_t'(wd_o));
		end
		if (exp_has_data) begin
			assert (wdata_o === exp_wdata) else mismatch("wdata_o", exp_wdata, wdata_o);
		end
		if (exp_whilo) begin
			assert (hi_o === exp_hi) else mismatch("hi_o", exp_hi, hi_o);
			assert (lo_o === exp_lo) else mismatch("lo_o", exp_lo, lo_o);
		end
	endtask

	// expected result straight from the instruction definitions
	task automatic model_op(input aluop_t op, input word_t a, input word_t b, input logic wr);
		longint      wide;
		logic [63:0] prod;
		logic        ovf;
		ovf          = 1'b0;
		exp_has_data = 1'b1;
		exp_whilo    = 1'b0;
		exp_wdata    = '0;
		case (op)
			EXE_AND_OP:  exp_wdata = a & b;
			EXE_OR_OP:   exp_wdata = a | b;
			EXE_XOR_OP:  exp_wdata = a ^ b;
			EXE_NOR_OP:  exp_wdata = ~(a | b);
			EXE_SLL_OP:  exp_wdata = b << a[4:0];
			EXE_SRL_OP:  exp_wdata = b >> a[4:0];
			EXE_SRA_OP: begin
				exp_wdata = b >> a[4:0];
				// vacated top bits take the sign of operand 2
				if (b[`EXEC_DATA_W-1])
					exp_wdata = exp_wdata | ~(32'hffff_ffff >> a[4:0]);
			end
			EXE_ADD_OP, EXE_ADDU_OP, EXE_SUB_OP, EXE_SUBU_OP: begin
				if (op == EXE_ADD_OP || op == EXE_ADDU_OP)
					wide = longint'($signed(a)) + longint'($signed(b));
				else
					wide = longint'($signed(a)) - longint'($signed(b));
				exp_wdata = word_t'(wide);
				// the exact result does not fit a signed word
				ovf = (op == EXE_ADD_OP || op == EXE_SUB_OP) &&
					(wide != longint'($signed(exp_wdata)));
			end
			EXE_SLT_OP:  exp_wdata = ($signed(a) < $signed(b)) ? 1 : 0;
			EXE_SLTU_OP: exp_wdata = (a < b) ? 1 : 0;
			EXE_CLZ_OP:  exp_wdata = count_lead(a, 1'b0);
			EXE_CLO_OP:  exp_wdata = count_lead(a, 1'b1);
			EXE_MUL_OP:  exp_wdata = word_t'(longint'($signed(a)) * longint'($signed(b)));
			EXE_MULT_OP, EXE_MULTU_OP: begin
				if (op == EXE_MULT_OP)
					prod = longint'($signed(a)) * longint'($signed(b));
				else
					prod = 64'(a) * 64'(b);
				{hi_m, lo_m} = prod;
				exp_whilo    = 1'b1;
				exp_has_data = 1'b0;
			end
			EXE_MFHI_OP: exp_wdata = hi_m;
			EXE_MFLO_OP: exp_wdata = lo_m;
			EXE_MTHI_OP, EXE_MTLO_OP: begin
				if (op == EXE_MTHI_OP)
					hi_m = a;
				else
					lo_m = a;
				exp_whilo    = 1'b1;
				exp_has_data = 1'b0;
			end
			default:     exp_has_data = 1'b0;
		endcase
		exp_hi   = hi_m;
		exp_lo   = lo_m;
		exp_wreg = wr & ~ovf;
	endtask

	// bubble with junk operands where nothing may be written
	task automatic idle();
		@(negedge clk);
		check_outputs();
		valid_i      = 1'b0;
		reg1_i       = $urandom;
		reg2_i       = $urandom;
		wd_i         = reg_addr_t'($urandom);
		wreg_i       = 1'b1;
		exp_valid    = 1'b0;
		exp_wreg     = 1'b0;
		exp_whilo    = 1'b0;
		exp_has_data = 1'b0;
	endtask

	task automatic issue(input aluop_t op, input word_t a, input word_t b, input logic wr);
		@(negedge clk);
		check_outputs();
		valid_i   = 1'b1;
		aluop_i   = op;
		reg1_i    = a;
		reg2_i    = b;
		wd_i      = reg_addr_t'($urandom);
		wreg_i    = wr;
		exp_valid = 1'b1;
		exp_wd    = wd_i;
		model_op(op, a, b, wr);
		if (idle_en && $urandom_range(3, 0) == 0)
			idle();
	endtask

	initial begin
		void'($urandom(32'hdae));
		valid_i      = 1'b0;
		aluop_i      = EXE_NOP_OP;
		reg1_i       = '0;
		reg2_i       = '0;
		wd_i         = '0;
		wreg_i       = 1'b0;
		hi_m         = `EXEC_HILO_RESET;
		lo_m         = `EXEC_HILO_RESET;
		exp_valid    = 1'b0;
		exp_wreg     = 1'b0;
		exp_whilo    = 1'b0;
		exp_has_data = 1'b0;
		idle_en      = 1'b1;

		test_name = "reset";
		repeat (RST_CYCLES) begin
			@(negedge clk);
			check_outputs();
		end
		issue(EXE_MFHI_OP, $urandom, $urandom, 1'b1);

		test_name = "logic_shift";
		for (int i = 0; i < N_RAND; i++) begin
			foreach (ls_ops[k])
				issue(ls_ops[k], $urandom, $urandom, 1'($urandom));
		end

		test_name = "add_sub";
		for (int i = 0; i < N_RAND; i++) begin
			foreach (add_ops[k])
				issue(add_ops[k], $urandom, $urandom, 1'($urandom));
		end
		test_name = "overflow";
		issue(EXE_ADD_OP,  32'h7fff_ffff, 32'h0000_0001, 1'b1);
		issue(EXE_ADDU_OP, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
		issue(EXE_ADD_OP,  32'h8000_0000, 32'h8000_0000, 1'b1);
		issue(EXE_ADDU_OP, 32'h8000_0000, 32'h8000_0000, 1'b1);
		issue(EXE_SUB_OP,  32'h8000_0000, 32'h0000_0001, 1'b1);
		issue(EXE_SUBU_OP, 32'h8000_0000, 32'h0000_0001, 1'b1);
		issue(EXE_SUB_OP,  32'h7fff_ffff, 32'hffff_ffff, 1'b1);
		issue(EXE_SUBU_OP, 32'h7fff_ffff, 32'hffff_ffff, 1'b1);

		test_name = "compare_count";
		for (int i = 0; i < N_RAND; i++) begin
			foreach (cmp_ops[k])
				issue(cmp_ops[k], $urandom, $urandom, 1'($urandom));
		end
		foreach (corners[m]) begin
			issue(EXE_CLZ_OP, corners[m], $urandom, 1'b1);
			issue(EXE_CLO_OP, corners[m], $urandom, 1'b1);
			foreach (corners[n]) begin
				issue(EXE_SLT_OP, corners[m], corners[n], 1'b1);
				issue(EXE_SLTU_OP, corners[m], corners[n], 1'b1);
			end
		end

		// back to back so the reads go through the forwarding path
		test_name = "multiply";
		idle_en   = 1'b0;
		for (int i = 0; i < N_RAND; i++) begin
			issue(EXE_MUL_OP, $urandom, $urandom, 1'($urandom));
			issue(EXE_MULT_OP, $urandom, $urandom, 1'b0);
			issue(EXE_MFHI_OP, $urandom, $urandom, 1'b1);
			issue(EXE_MFLO_OP, $urandom, $urandom, 1'b1);
			issue(EXE_MULTU_OP, $urandom, $urandom, 1'b0);
			issue(EXE_MFLO_OP, $urandom, $urandom, 1'b1);
			issue(EXE_MFHI_OP, $urandom, $urandom, 1'b1);
			// MTLO keeps the HI value still pending from MTHI
			issue(EXE_MTHI_OP, $urandom, $urandom, 1'b0);
			issue(EXE_MTLO_OP, $urandom, $urandom, 1'b0);
		end

		test_name = "hilo_move";
		idle_en   = 1'b1;
		for (int i = 0; i < N_RAND; i++) begin
			issue(EXE_MTHI_OP, $urandom, $urandom, 1'b0);
			issue(EXE_MFHI_OP, $urandom, $urandom, 1'b1);
			issue(EXE_MFLO_OP, $urandom, $urandom, 1'b1);
			issue(EXE_MTLO_OP, $urandom, $urandom, 1'b0);
			issue(EXE_MFLO_OP, $urandom, $urandom, 1'b1);
			issue(EXE_MFHI_OP, $urandom, $urandom, 1'b1);
		end

		// drain the last result
		test_name = "drain";
		idle();
		idle();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- ex_stage.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/logic_shift_unit.sv
verilog/arith_unit.sv
verilog/mult_unit.sv
verilog/hilo_file.sv
verilog/ex_stage.sv
tests/tb_clock_gen.sv
tests/tb_ex_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ex_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f ex_stage.f --top-module tb_ex_stage -o sim_tb_ex_stage

# a failing run exits non-zero, the log is searched instead
./obj_dir/sim_tb_ex_stage > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF '*** FAILED ***' "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if ! grep -qF '*** PASSED ***' "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
